//--- compile.f
rdc_pkg.sv
rd_req_fifo.sv
rd_credit_gate.sv
rd_csr_wb.sv
rd_cred_top.sv
tb_rd_cred.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the read-credit gate testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rd_cred -f compile.f -o sim_rd_cred
./obj_dir/sim_rd_cred | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

//--- tb_rd_cred.sv
`timescale 1ns/10ps

module tb_rd_cred;

  import rdc_pkg::*;

  localparam integer DATA_BITS   = 64;
  localparam integer MAX_CREDITS = 8;
  localparam integer BEAT_BYTES  = DATA_BITS / 8;
  localparam logic [CREDIT_BITS-1:0] MAX_LIM = CREDIT_BITS'(MAX_CREDITS);

  // Cycle budget per test for worst case lengths
  localparam integer T1_CYC = 100;
  localparam integer T2_CYC = 100;
  localparam integer T3_CYC = 200;
  localparam integer T4_CYC = 1200;
  localparam integer T5_CYC = 300;
  localparam integer LIMIT  = T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 1100;

  logic                   aclk;
  logic                   aresetn;
  logic                   req_valid;
  logic                   req_ready;
  logic [ADDR_BITS-1:0]   req_addr;
  logic [LEN_BITS-1:0]    req_len;
  logic [DEST_BITS-1:0]   req_dest;
  logic                   mem_valid;
  logic                   mem_ready;
  logic [ADDR_BITS-1:0]   mem_addr;
  logic [LEN_BITS-1:0]    mem_len;
  logic                   rvalid;
  logic [DATA_BITS-1:0]   rdata;
  logic                   out_valid;
  logic [DATA_BITS-1:0]   out_data;
  logic [DEST_BITS-1:0]   out_dest;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [1:0]             wb_adr;
  logic [31:0]            wb_dat_w;
  logic [31:0]            wb_dat_r;
  logic                   wb_ack;

  // Requests seen by the memory model in arrival order
  logic [ADDR_BITS-1:0]   mq_addr[$];
  logic [LEN_BITS-1:0]    mq_len[$];
  logic [DEST_BITS-1:0]   mq_dest[$];
  int                     mq_cyc[$];

  int cyc;
  int hs_count;
  int err_count;
  int tests_run;
  int tests_ok;

  rd_cred_top #(
    .DATA_BITS   (DATA_BITS),
    .MAX_CREDITS (MAX_CREDITS)
  ) uut (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .req_len   (req_len),
    .req_dest  (req_dest),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_len   (mem_len),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_dest  (out_dest),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

  always #50 aclk = ~aclk;

  always @(posedge aclk) begin
    cyc <= cyc + 1;
  end

  // Memory side handshake capture at mid-cycle where inputs are settled
  always @(negedge aclk) begin
    if (aresetn && mem_valid && mem_ready) begin
      mq_addr.push_back(mem_addr);
      mq_len.push_back(mem_len);
      mq_dest.push_back(req_dest);
      mq_cyc.push_back(cyc);
      hs_count++;
    end
  end

  initial begin : watchdog
    while (cyc < LIMIT) begin
      @(posedge aclk);
    end
    $display("timeout after %0d cycles, DUT stopped responding", cyc);
    $display("tests failed");
    $finish;
  end

  // CTRL word with enable in bit 0 and limit in bits 7:4
  function automatic logic [31:0] ctrl_word(input logic en, input logic [CREDIT_BITS-1:0] lim);
    ctrl_word = {24'b0, lim, 3'b0, en};
  endfunction

  task automatic check_dest(input string name, input logic [DEST_BITS-1:0] got,
                            input logic [DEST_BITS-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_beat(input string name, input logic [DATA_BITS-1:0] got,
                            input logic [DATA_BITS-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
    @(posedge aclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    do @(negedge aclk); while (!wb_ack);
    @(posedge aclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
    @(posedge aclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do @(negedge aclk); while (!wb_ack);
    // Read data only valid during ack
    dat = wb_dat_r;
    @(posedge aclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic drive_req(input logic [ADDR_BITS-1:0] addr, input logic [LEN_BITS-1:0] len,
                           input logic [DEST_BITS-1:0] dest);
    @(posedge aclk);
    req_valid <= 1'b1;
    req_addr  <= addr;
    req_len   <= len;
    req_dest  <= dest;
  endtask

  // Returns on the cycle whose closing edge takes the request
  task automatic wait_accept();
    @(negedge aclk);
    while (!req_ready) begin
      @(negedge aclk);
    end
  endtask

  task automatic send_req(input logic [ADDR_BITS-1:0] addr, input logic [LEN_BITS-1:0] len,
                          input logic [DEST_BITS-1:0] dest);
    drive_req(addr, len, dest);
    wait_accept();
  endtask

  task automatic req_idle();
    @(posedge aclk);
    req_valid <= 1'b0;
  endtask

  // Returns all beats of the oldest request and leaves rvalid high after the last beat
  task automatic return_one();
    logic [ADDR_BITS-1:0] a;
    logic [LEN_BITS-1:0]  l;
    logic [DEST_BITS-1:0] d;
    logic [DATA_BITS-1:0] exp;
    int                   acc;
    int                   nb;
    while (mq_addr.size() == 0) begin
      @(posedge aclk);
      rvalid <= 1'b0;
    end
    a   = mq_addr.pop_front();
    l   = mq_len.pop_front();
    d   = mq_dest.pop_front();
    acc = mq_cyc.pop_front();
    // First beat no sooner than 3 cycles after accept
    while (cyc < acc + 3) begin
      @(posedge aclk);
      rvalid <= 1'b0;
    end
    // Beat count rounded up from the byte length
    nb = (int'(l) + BEAT_BYTES - 1) / BEAT_BYTES;
    for (int i = 0; i < nb; i++) begin
      exp = DATA_BITS'(a) + DATA_BITS'(i);
      @(posedge aclk);
      rvalid <= 1'b1;
      rdata  <= exp;
      @(negedge aclk);
      if (out_valid !== 1'b1) begin
        err_count++;
        $display("out_valid missing on a returned beat");
      end
      check_dest("out_dest", out_dest, d);
      check_beat("out_data", out_data, exp);
    end
  endtask

  task automatic idle_data();
    @(posedge aclk);
    rvalid <= 1'b0;
  endtask

  // Request held off for n cycles with nothing sent to memory
  task automatic expect_stalled(input int n);
    repeat (n) begin
      @(negedge aclk);
      if (req_ready) begin
        err_count++;
        $display("req_ready rose while the request should have been held off");
      end
      if (mem_valid) begin
        err_count++;
        $display("mem_valid rose while the request should have been held off");
      end
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    tests_run++;
    if (err_count == e0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, err_count - e0);
    end
  endtask

  task automatic reg_access();
    int          e0;
    logic [31:0] rd;
    e0 = err_count;
    // Reset values
    wb_read(REG_CTRL, rd);
    check_word("CTRL", rd, ctrl_word(1'b1, MAX_LIM));
    wb_read(REG_STATUS, rd);
    check_word("STATUS", rd, 32'd0);
    wb_read(REG_ISSUED, rd);
    check_word("ISSUED", rd, 32'd0);
    wb_read(REG_DONE, rd);
    check_word("DONE", rd, 32'd0);
    wb_write(REG_CTRL, ctrl_word(1'b1, 4'd3));
    wb_read(REG_CTRL, rd);
    check_word("CTRL", rd, ctrl_word(1'b1, 4'd3));
    // Above MAX_CREDITS reads back clamped
    wb_write(REG_CTRL, ctrl_word(1'b1, 4'd15));
    wb_read(REG_CTRL, rd);
    check_word("CTRL", rd, ctrl_word(1'b1, MAX_LIM));
    finish_test("register access", e0);
  endtask

  task automatic single_read();
    int          e0;
    logic [31:0] rd;
    e0 = err_count;
    // 20 bytes make 3 beats
    send_req(32'h0000_1000, 16'd20, 4'd5);
    req_idle();
    return_one();
    idle_data();
    wb_read(REG_DONE, rd);
    check_word("DONE", rd, 32'd1);
    wb_read(REG_ISSUED, rd);
    check_word("ISSUED", rd, 32'd1);
    wb_read(REG_STATUS, rd);
    check_word("STATUS", rd, 32'd0);
    finish_test("single request", e0);
  endtask

  task automatic credit_throttle();
    int          e0;
    int          hs0;
    logic [31:0] rd;
    e0 = err_count;
    wb_write(REG_CTRL, ctrl_word(1'b1, 4'd2));
    hs0 = hs_count;
    fork
      begin
        for (int k = 0; k < 4; k++) begin
          send_req(32'h2000 + 32'(k) * 32'h100, 16'd16, 4'(k + 8));
        end
        req_idle();
      end
      begin
        // No data back yet so only two get through
        repeat (20) @(posedge aclk);
        check_word("mem handshakes", 32'(hs_count - hs0), 32'd2);
        wb_read(REG_STATUS, rd);
        check_word("STATUS", rd, 32'd2);
        return_one();
        idle_data();
        repeat (10) @(posedge aclk);
        // One freed credit lets one more request through
        check_word("mem handshakes", 32'(hs_count - hs0), 32'd3);
        repeat (3) begin
          return_one();
        end
        idle_data();
      end
    join
    wb_write(REG_CTRL, ctrl_word(1'b1, MAX_LIM));
    finish_test("credit limit", e0);
  endtask

  task automatic ordered_stream();
    int          e0;
    logic [31:0] rd;
    e0 = err_count;
    wb_write(REG_ISSUED, 32'd0);
    wb_write(REG_DONE, 32'd0);
    fork
      begin
        repeat (20) begin
          send_req($urandom, LEN_BITS'($urandom_range(64, 1)), DEST_BITS'($urandom_range(15, 0)));
        end
        req_idle();
      end
      begin
        // Back to back returns cross request boundaries
        repeat (20) begin
          return_one();
        end
        idle_data();
      end
    join
    wb_read(REG_ISSUED, rd);
    check_word("ISSUED", rd, 32'd20);
    wb_read(REG_DONE, rd);
    check_word("DONE", rd, 32'd20);
    wb_read(REG_STATUS, rd);
    check_word("STATUS", rd, 32'd0);
    // Any written value clears
    wb_write(REG_ISSUED, 32'hffff_ffff);
    wb_write(REG_DONE, 32'h1);
    wb_read(REG_ISSUED, rd);
    check_word("ISSUED", rd, 32'd0);
    wb_read(REG_DONE, rd);
    check_word("DONE", rd, 32'd0);
    finish_test("stream ordering", e0);
  endtask

  task automatic enable_stall();
    int          e0;
    int          hs0;
    logic [31:0] rd;
    e0 = err_count;
    // Disabled gate holds the request
    wb_write(REG_CTRL, ctrl_word(1'b0, MAX_LIM));
    hs0 = hs_count;
    drive_req(32'hA000_0040, 16'd24, 4'd9);
    expect_stalled(20);
    check_word("mem handshakes", 32'(hs_count - hs0), 32'd0);
    wb_write(REG_CTRL, ctrl_word(1'b1, MAX_LIM));
    wait_accept();
    req_idle();
    check_word("mem handshakes", 32'(hs_count - hs0), 32'd1);
    check_word("mem_addr", mq_addr[mq_addr.size()-1], 32'hA000_0040);
    check_word("mem_len", 32'(mq_len[mq_len.size()-1]), 32'd24);
    return_one();
    idle_data();
    // Memory not ready
    @(posedge aclk);
    mem_ready <= 1'b0;
    hs0 = hs_count;
    drive_req(32'hB000_0100, 16'd9, 4'd3);
    expect_stalled(20);
    @(posedge aclk);
    mem_ready <= 1'b1;
    wait_accept();
    req_idle();
    check_word("mem handshakes", 32'(hs_count - hs0), 32'd1);
    check_word("mem_addr", mq_addr[mq_addr.size()-1], 32'hB000_0100);
    check_word("mem_len", 32'(mq_len[mq_len.size()-1]), 32'd9);
    return_one();
    idle_data();
    wb_read(REG_STATUS, rd);
    check_word("STATUS", rd, 32'd0);
    finish_test("enable and stall", e0);
  endtask

  initial begin
    void'($urandom(64));
    aclk      = 1'b0;
    aresetn   <= 1'b0;
    req_valid <= 1'b0;
    req_addr  <= '0;
    req_len   <= '0;
    req_dest  <= '0;
    mem_ready <= 1'b1;
    rvalid    <= 1'b0;
    rdata     <= '0;
    wb_cyc    <= 1'b0;
    wb_stb    <= 1'b0;
    wb_we     <= 1'b0;
    wb_adr    <= '0;
    wb_dat_w  <= '0;
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;

    reg_access();
    single_read();
    credit_throttle();
    ordered_stream();
    enable_stall();

    $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, err_count);
    if (err_count == 0 && tests_ok == tests_run) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- rd_cred_top.sv
`timescale 1ns/10ps

module rd_cred_top #(
  parameter integer DATA_BITS   = 64,
  parameter integer MAX_CREDITS = 8
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // Client requests
  input  logic                          req_valid,
  output logic                          req_ready,
  input  logic [rdc_pkg::ADDR_BITS-1:0] req_addr,
  input  logic [rdc_pkg::LEN_BITS-1:0]  req_len,
  input  logic [rdc_pkg::DEST_BITS-1:0] req_dest,
  // Memory read port
  output logic                          mem_valid,
  input  logic                          mem_ready,
  output logic [rdc_pkg::ADDR_BITS-1:0] mem_addr,
  output logic [rdc_pkg::LEN_BITS-1:0]  mem_len,
  input  logic                          rvalid,
  input  logic [DATA_BITS-1:0]          rdata,
  // Tagged read data
  output logic                          out_valid,
  output logic [DATA_BITS-1:0]          out_data,
  output logic [rdc_pkg::DEST_BITS-1:0] out_dest,
  // Wishbone classic slave
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [1:0]                    wb_adr,
  input  logic [31:0]                   wb_dat_w,
  output logic [31:0]                   wb_dat_r,
  output logic                          wb_ack
);

  import rdc_pkg::*;

  // Queue entry is tag plus beats minus one
  localparam integer Q_BITS = DEST_BITS + LEN_BITS - $clog2(DATA_BITS / 8);

  logic                   enable;
  logic [CREDIT_BITS-1:0] credit_limit;
  logic [CREDIT_BITS-1:0] in_flight;
  logic                   issue_pulse;
  logic                   done_pulse;
  logic                   fifo_push;
  logic                   fifo_pop;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic [Q_BITS-1:0]      fifo_push_data;
  logic [Q_BITS-1:0]      fifo_head;

  // Beats are never stalled, data passes straight out
  assign out_valid = rvalid;
  assign out_data  = rdata;

  rd_credit_gate #(
    .DATA_BITS   (DATA_BITS),
    .MAX_CREDITS (MAX_CREDITS)
  ) u_gate (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_addr       (req_addr),
    .req_len        (req_len),
    .req_dest       (req_dest),
    .mem_valid      (mem_valid),
    .mem_ready      (mem_ready),
    .mem_addr       (mem_addr),
    .mem_len        (mem_len),
    .rvalid         (rvalid),
    .rd_dest        (out_dest),
    .enable         (enable),
    .credit_limit   (credit_limit),
    .in_flight      (in_flight),
    .issue_pulse    (issue_pulse),
    .done_pulse     (done_pulse),
    .fifo_push      (fifo_push),
    .fifo_push_data (fifo_push_data),
    .fifo_pop       (fifo_pop),
    .fifo_full      (fifo_full),
    .fifo_empty     (fifo_empty),
    .fifo_head      (fifo_head)
  );

  // One slot per credit
  rd_req_fifo #(
    .WIDTH (Q_BITS),
    .DEPTH (MAX_CREDITS)
  ) u_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (fifo_push),
    .push_data (fifo_push_data),
    .full      (fifo_full),
    .pop       (fifo_pop),
    .pop_data  (fifo_head),
    .empty     (fifo_empty)
  );

  rd_csr_wb #(
    .MAX_CREDITS (MAX_CREDITS)
  ) u_csr (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .in_flight    (in_flight),
    .issue_pulse  (issue_pulse),
    .done_pulse   (done_pulse),
    .enable       (enable),
    .credit_limit (credit_limit)
  );

endmodule

//--- rd_csr_wb.sv
`timescale 1ns/10ps

module rd_csr_wb #(
  parameter integer MAX_CREDITS = 8
) (
  input  logic                            aclk,
  input  logic                            aresetn,
  // Wishbone classic slave
  input  logic                            wb_cyc,
  input  logic                            wb_stb,
  input  logic                            wb_we,
  input  logic [1:0]                      wb_adr,
  input  logic [31:0]                     wb_dat_w,
  output logic [31:0]                     wb_dat_r,
  output logic                            wb_ack,
  // Gate status and events
  input  logic [rdc_pkg::CREDIT_BITS-1:0] in_flight,
  input  logic                            issue_pulse,
  input  logic                            done_pulse,
  // Gate control
  output logic                            enable,
  output logic [rdc_pkg::CREDIT_BITS-1:0] credit_limit
);

  import rdc_pkg::*;

  localparam logic [CREDIT_BITS-1:0] MAX_LIMIT = CREDIT_BITS'(MAX_CREDITS);

  logic                   req;
  logic                   wr_en;
  logic [CREDIT_BITS-1:0] wr_limit;
  logic [31:0]            issued_cnt;
  logic [31:0]            done_cnt;

  // New access, ack not yet given
  assign req = wb_cyc && wb_stb && !wb_ack;

  // Writes land at the end of the ack cycle
  assign wr_en = wb_ack && wb_cyc && wb_stb && wb_we;

  // Limit field with clamp
  assign wr_limit = (wb_dat_w[CTRL_LIM_LSB +: CREDIT_BITS] > MAX_LIMIT) ?
                    MAX_LIMIT : wb_dat_w[CTRL_LIM_LSB +: CREDIT_BITS];

  // Single-cycle ack
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // CTRL register
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      enable       <= 1'b1;
      credit_limit <= MAX_LIMIT;
    end else if (wr_en && (wb_adr == REG_CTRL)) begin
      enable       <= wb_dat_w[CTRL_EN_BIT];
      credit_limit <= wr_limit;
    end
  end

  // Accepted requests, clear on any write
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      issued_cnt <= '0;
    end else if (wr_en && (wb_adr == REG_ISSUED)) begin
      issued_cnt <= '0;
    end else if (issue_pulse) begin
      issued_cnt <= issued_cnt + 1'b1;
    end
  end

  // Completed requests, clear on any write
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      done_cnt <= '0;
    end else if (wr_en && (wb_adr == REG_DONE)) begin
      done_cnt <= '0;
    end else if (done_pulse) begin
      done_cnt <= done_cnt + 1'b1;
    end
  end

  // Read mux, address held by the master through ack
  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      REG_CTRL: begin
        wb_dat_r[CTRL_EN_BIT]                  = enable;
        wb_dat_r[CTRL_LIM_LSB +: CREDIT_BITS]  = credit_limit;
      end
      REG_STATUS: begin
        wb_dat_r[CREDIT_BITS-1:0] = in_flight;
      end
      REG_ISSUED: begin
        wb_dat_r = issued_cnt;
      end
      REG_DONE: begin
        wb_dat_r = done_cnt;
      end
      default: begin
        wb_dat_r = '0;
      end
    endcase
  end

endmodule

//--- rd_credit_gate.sv
`timescale 1ns/10ps

module rd_credit_gate #(
  parameter integer DATA_BITS   = 64,
  parameter integer MAX_CREDITS = 8
) (
  input  logic                            aclk,
  input  logic                            aresetn,
  // Client requests
  input  logic                            req_valid,
  output logic                            req_ready,
  input  logic [rdc_pkg::ADDR_BITS-1:0]   req_addr,
  input  logic [rdc_pkg::LEN_BITS-1:0]    req_len,
  input  logic [rdc_pkg::DEST_BITS-1:0]   req_dest,
  // Memory read port
  output logic                            mem_valid,
  input  logic                            mem_ready,
  output logic [rdc_pkg::ADDR_BITS-1:0]   mem_addr,
  output logic [rdc_pkg::LEN_BITS-1:0]    mem_len,
  // Returning beats
  input  logic                            rvalid,
  output logic [rdc_pkg::DEST_BITS-1:0]   rd_dest,
  // Register block
  input  logic                            enable,
  input  logic [rdc_pkg::CREDIT_BITS-1:0] credit_limit,
  output logic [rdc_pkg::CREDIT_BITS-1:0] in_flight,
  output logic                            issue_pulse,
  output logic                            done_pulse,
  // Outstanding queue
  output logic                            fifo_push,
  output logic [rdc_pkg::DEST_BITS+rdc_pkg::LEN_BITS-$clog2(DATA_BITS/8)-1:0] fifo_push_data,
  output logic                            fifo_pop,
  input  logic                            fifo_full,
  input  logic                            fifo_empty,
  input  logic [rdc_pkg::DEST_BITS+rdc_pkg::LEN_BITS-$clog2(DATA_BITS/8)-1:0] fifo_head
);

  import rdc_pkg::*;

  // Bytes per beat as a shift
  localparam integer BEAT_LOG = $clog2(DATA_BITS / 8);
  // Beat count width after the shift
  localparam integer CNT_BITS = LEN_BITS - BEAT_LOG;
  localparam logic [CREDIT_BITS-1:0] MAX_LIMIT = CREDIT_BITS'(MAX_CREDITS);

  // FSM states
  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_READ = 1'b1;

  logic                   state_c, state_n;
  logic [CREDIT_BITS-1:0] in_flight_c, in_flight_n;
  logic [CNT_BITS-1:0]    cnt_c, cnt_n;
  logic [CNT_BITS-1:0]    n_beats_c, n_beats_n;
  logic [DEST_BITS-1:0]   dest_c, dest_n;

  logic [CREDIT_BITS-1:0] eff_limit;
  logic [LEN_BITS-1:0]    len_m1;
  logic [CNT_BITS-1:0]    head_beats;
  logic [DEST_BITS-1:0]   head_dest;
  logic                   credit_ok;
  logic                   req_sent;
  logic                   req_done;

  // Never more in flight than the queue holds
  assign eff_limit = (credit_limit > MAX_LIMIT) ? MAX_LIMIT : credit_limit;

  // Last beat of the head entry
  assign req_done = (state_c == ST_READ) && rvalid && (cnt_c == n_beats_c);

  // A completing request hands its credit straight to a new one
  assign credit_ok = (in_flight_c < eff_limit) || req_done;
  assign req_sent  = req_valid && mem_ready && enable && !fifo_full && credit_ok;

  // Pass-through to memory
  assign req_ready = req_sent;
  assign mem_valid = req_sent;
  assign mem_addr  = req_addr;
  assign mem_len   = req_len;

  // Beats minus one, ceil(len / beat bytes) - 1
  assign len_m1         = req_len - 1'b1;
  assign fifo_push      = req_sent;
  assign fifo_push_data = {req_dest, len_m1[LEN_BITS-1:BEAT_LOG]};

  // Queue entry split
  assign head_beats = fifo_head[CNT_BITS-1:0];
  assign head_dest  = fifo_head[CNT_BITS +: DEST_BITS];

  assign issue_pulse = req_sent;
  assign done_pulse  = req_done;
  assign in_flight   = in_flight_c;
  assign rd_dest     = dest_c;

  // Credit accounting
  always_comb begin
    in_flight_n = in_flight_c;
    if (req_sent && !req_done) begin
      in_flight_n = in_flight_c + 1'b1;
    end else if (req_done && !req_sent) begin
      in_flight_n = in_flight_c - 1'b1;
    end
  end

  // Head load and beat counting
  always_comb begin
    state_n   = state_c;
    cnt_n     = cnt_c;
    n_beats_n = n_beats_c;
    dest_n    = dest_c;
    fifo_pop  = 1'b0;

    case (state_c)
      ST_IDLE: begin
        cnt_n = '0;
        if (!fifo_empty) begin
          fifo_pop  = 1'b1;
          n_beats_n = head_beats;
          dest_n    = head_dest;
          state_n   = ST_READ;
        end
      end

      ST_READ: begin
        if (req_done) begin
          cnt_n = '0;
          // Next entry loaded on the last beat, no bubble
          if (!fifo_empty) begin
            fifo_pop  = 1'b1;
            n_beats_n = head_beats;
            dest_n    = head_dest;
          end else begin
            state_n = ST_IDLE;
          end
        end else if (rvalid) begin
          cnt_n = cnt_c + 1'b1;
        end
      end

      default: begin
        state_n = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_c     <= ST_IDLE;
      in_flight_c <= '0;
      cnt_c       <= '0;
      dest_c      <= '0;
    end else begin
      state_c     <= state_n;
      in_flight_c <= in_flight_n;
      cnt_c       <= cnt_n;
      dest_c      <= dest_n;
    end
  end

  // Beat target, only read in ST_READ
  always_ff @(posedge aclk) begin
    n_beats_c <= n_beats_n;
  end

endmodule

//--- rd_req_fifo.sv
`timescale 1ns/10ps

module rd_req_fifo #(
  parameter integer WIDTH = 17,
  parameter integer DEPTH = 8
) (
  input  logic             aclk,
  input  logic             aresetn,
  // Write side
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             full,
  // Read side
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty
);

  // Pointer width kept at 1 or more for a depth of one
  localparam integer PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam integer CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  // Illegal accesses dropped here
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full     = (count == FULL_CNT);
  assign empty    = (count == '0);
  // Head entry shown as long as something is stored
  assign pop_data = mem[rd_ptr];

  // Storage array
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at DEPTH, depth need not be a power of two
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rdc_pkg.sv
package rdc_pkg;

  // Request address width
  localparam integer ADDR_BITS = 32;

  // Request length in bytes, never 0
  localparam integer LEN_BITS = 16;

  // Destination tag carried with each request
  localparam integer DEST_BITS = 4;

  // Credit limit and in-flight count, up to 15 credits
  localparam integer CREDIT_BITS = 4;

  // Wishbone word addresses of the register block
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_STATUS = 2'd1;
  localparam logic [1:0] REG_ISSUED = 2'd2;
  localparam logic [1:0] REG_DONE   = 2'd3;

  // CTRL field positions
  localparam integer CTRL_EN_BIT   = 0;
  localparam integer CTRL_LIM_LSB  = 4;

endpackage
